// ==== hdl/aluOpPkg.sv ====
`default_nettype none

package aluOpPkg;

  localparam int dataWidth     = 32;
  localparam int shiftAmtWidth = 5;

  // bit positions inside an NZCV nibble
  localparam int flagN = 3;
  localparam int flagZ = 2;
  localparam int flagC = 1;
  localparam int flagV = 0;

  typedef enum logic [4:0] {
    opAdd   = 5'b00000,
    opSub   = 5'b00001,
    opAnd   = 5'b00010,
    opOr    = 5'b00011,
    opXor   = 5'b00100,
    opSlt   = 5'b00101, // riscv only
    opPassB = 5'b00110,
    opSltu  = 5'b00111, // riscv only
    opSll   = 5'b01000, // riscv only
    opSrl   = 5'b01001, // riscv only
    opSra   = 5'b01010, // riscv only
    opMulLo = 5'b01100,
    opMulHi = 5'b01101,
    opBic   = 5'b10000, // arm only
    opAdc   = 5'b10010, // arm only
    opSbc   = 5'b10011, // arm only
    opRsb   = 5'b10100, // arm only
    opRsc   = 5'b10110, // arm only
    opMvn   = 5'b10111, // arm only
    opPassA = 5'b11111  // arm only
  } aluOp_t;

  typedef enum logic [1:0] {
    shLsl = 2'b00,
    shLsr = 2'b01,
    shAsr = 2'b10,
    shRor = 2'b11
  } shiftKind_t;

  typedef struct packed {
    logic                     isArm;
    aluOp_t                   op;
    logic [dataWidth-1:0]     op1;
    logic [dataWidth-1:0]     op2;
    shiftKind_t               shiftKind;
    logic                     shiftImm; // arm: 1 = shiftAmt, 0 = op1[4:0]
    logic [shiftAmtWidth-1:0] shiftAmt;
    logic [3:0]               flagsIn;  // nzcv
  } aluReq_t;

  typedef struct packed {
    logic [dataWidth-1:0] value;
    logic [3:0]           flags; // nzcv
  } aluResult_t;

endpackage

`default_nettype wire

// ==== hdl/aluPipePkg.sv ====
`default_nettype none

package aluPipePkg;

  import aluOpPkg::*;

  // register stages between request capture and result
  localparam int pipeDepth = 3;

  // payload leaving the operand stage
  typedef struct packed {
    logic                 isArm;
    aluOp_t               op;
    logic [dataWidth-1:0] op1;
    logic [dataWidth-1:0] opB;      // second operand after arm shift
    logic [dataWidth-1:0] shiftOut; // raw shifter output
    logic [3:0]           flagsIn;
  } shiftedOp_t;

  // payload leaving the compute stage
  typedef struct packed {
    logic [dataWidth-1:0] value;
    logic                 addCarry;
    logic                 addOverflow;
    logic                 usesAdder; // c and v come from the adder
    logic [3:0]           flagsIn;
  } computed_t;

endpackage

`default_nettype wire

// ==== hdl/stageReg.sv ====
`timescale 1ns/10ps
`default_nettype none

module stageReg #(
  parameter type payload_t = logic [31:0]
) (
  input  logic     clk,
  input  logic     reset,
  input  logic     inValid,
  input  payload_t inData,
  output logic     hold,
  output logic     outValid,
  output payload_t outData,
  input  logic     downHold
);

  logic load;

  assign hold = outValid & downHold; // full and stuck
  assign load = ~hold;               // empty, or full and draining

  always_ff @(posedge clk) begin
    if (reset) begin
      outValid <= 1'b0;
    end else if (load) begin
      outValid <= inValid;
    end
  end

  always_ff @(posedge clk) begin
    if (load && inValid) begin
      outData <= inData;
    end
  end

  holdStable: assert property (@(posedge clk) disable iff (reset)
    outValid && downHold |=> $stable(outData))
    else $error("stageReg: payload changed while held downstream");

endmodule

`default_nettype wire

// ==== hdl/barrelShifter.sv ====
`timescale 1ns/10ps
`default_nettype none

module barrelShifter
  import aluOpPkg::*;
(
  input  logic [dataWidth-1:0]     a,
  input  logic [shiftAmtWidth-1:0] amount,
  input  shiftKind_t               kind,
  output logic [dataWidth-1:0]     q
);

  // index shiftAmtWidth is the input, index 0 the fully shifted word
  logic [dataWidth-1:0] lslStage [shiftAmtWidth+1];
  logic [dataWidth-1:0] rshStage [shiftAmtWidth+1];
  logic [dataWidth-1:0] rorStage [shiftAmtWidth+1];
  logic                 fill;

  assign fill = (kind == shAsr) & a[dataWidth-1]; // sign fill for asr only

  assign lslStage[shiftAmtWidth] = a;
  assign rshStage[shiftAmtWidth] = a;
  assign rorStage[shiftAmtWidth] = a;

  // level i moves by 2**i, largest step first
  for (genvar i = shiftAmtWidth - 1; i >= 0; i--) begin : gLevel
    assign lslStage[i] = amount[i] ?
      {lslStage[i+1][dataWidth-1-(1<<i):0], {(1 << i){1'b0}}} : lslStage[i+1];
    assign rshStage[i] = amount[i] ?
      {{(1 << i){fill}}, rshStage[i+1][dataWidth-1:(1<<i)]} : rshStage[i+1];
    assign rorStage[i] = amount[i] ?
      {rorStage[i+1][(1<<i)-1:0], rorStage[i+1][dataWidth-1:(1<<i)]} : rorStage[i+1];
  end

  always_comb begin
    case (kind)
      shLsl:   q = lslStage[0];
      shLsr:   q = rshStage[0];
      shAsr:   q = rshStage[0]; // fill already applied
      default: q = rorStage[0];
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/addSub.sv ====
`timescale 1ns/10ps
`default_nettype none

module addSub
  import aluOpPkg::*;
(
  input  logic [dataWidth-1:0] a,
  input  logic [dataWidth-1:0] b,
  input  logic                 invA,
  input  logic                 invB,
  input  logic                 useCarry,
  input  logic                 carryIn,
  output logic [dataWidth-1:0] sum,
  output logic                 carryOut,
  output logic                 overflow
);

  logic [dataWidth-1:0] effA;
  logic [dataWidth-1:0] effB;
  logic                 cin;

  assign effA = invA ? ~a : a;
  assign effB = invB ? ~b : b;

  // plain subtract needs the +1 of two's complement
  assign cin = useCarry ? carryIn : (invA ^ invB);

  assign {carryOut, sum} = {1'b0, effA} + {1'b0, effB} + {{dataWidth{1'b0}}, cin};

  // same-sign operands giving an opposite-sign sum
  assign overflow = (effA[dataWidth-1] == effB[dataWidth-1]) &
                    (sum[dataWidth-1] != effA[dataWidth-1]);

endmodule

`default_nettype wire

// ==== hdl/multiplier.sv ====
`timescale 1ns/10ps
`default_nettype none

module multiplier
  import aluOpPkg::*;
(
  input  logic [dataWidth-1:0]   a,
  input  logic [dataWidth-1:0]   b,
  output logic [2*dataWidth-1:0] product
);

  logic [2*dataWidth-1:0] wideA;
  logic [2*dataWidth-1:0] wideB;

  // zero extend so the product is unsigned at full width
  assign wideA = {{dataWidth{1'b0}}, a};
  assign wideB = {{dataWidth{1'b0}}, b};

  assign product = wideA * wideB;

endmodule

`default_nettype wire

// ==== hdl/operandStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module operandStage
  import aluOpPkg::*, aluPipePkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       reqValid,
  input  aluReq_t    reqData,
  output logic       reqAck,
  output logic       outValid,
  output shiftedOp_t outData,
  input  logic       downHold
);

  logic [dataWidth-1:0]     shiftIn;
  logic [dataWidth-1:0]     shiftOut;
  logic [shiftAmtWidth-1:0] shiftAmount;
  shiftKind_t               shiftKindSel;
  shiftedOp_t               stageIn;
  logic                     stageHold;
  logic                     capture;

  always_comb begin
    if (reqData.isArm) begin
      shiftIn      = reqData.op2;
      shiftAmount  = reqData.shiftImm ? reqData.shiftAmt : reqData.op1[shiftAmtWidth-1:0];
      shiftKindSel = reqData.shiftKind;
    end else begin
      shiftIn     = reqData.op1;
      shiftAmount = reqData.op2[shiftAmtWidth-1:0];
      case (reqData.op) // riscv shift kind lives in the opcode
        opSrl:   shiftKindSel = shLsr;
        opSra:   shiftKindSel = shAsr;
        default: shiftKindSel = shLsl;
      endcase
    end
  end

  barrelShifter shifter (
    .a      (shiftIn),
    .amount (shiftAmount),
    .kind   (shiftKindSel),
    .q      (shiftOut)
  );

  always_comb begin
    stageIn.isArm    = reqData.isArm;
    stageIn.op       = reqData.op;
    stageIn.op1      = reqData.op1;
    stageIn.opB      = reqData.isArm ? shiftOut : reqData.op2; // arm shifts operand 2
    stageIn.shiftOut = shiftOut;
    stageIn.flagsIn  = reqData.flagsIn;
  end

  // new item only in the open phase and with room downstream
  assign capture = reqValid & ~reqAck & ~stageHold;

  always_ff @(posedge clk) begin
    if (reset) begin
      reqAck <= 1'b0;
    end else if (capture) begin
      reqAck <= 1'b1;
    end else if (!reqValid) begin
      reqAck <= 1'b0; // return to zero
    end
  end

  stageReg #(.payload_t(shiftedOp_t)) stage2Reg (
    .clk      (clk),
    .reset    (reset),
    .inValid  (capture),
    .inData   (stageIn),
    .hold     (stageHold),
    .outValid (outValid),
    .outData  (outData),
    .downHold (downHold)
  );

  listedOp: assert property (@(posedge clk) disable iff (reset)
    capture |-> reqData.op inside {opAdd, opSub, opAnd, opOr, opXor, opSlt, opPassB,
                                   opSltu, opSll, opSrl, opSra, opMulLo, opMulHi, opBic,
                                   opAdc, opSbc, opRsb, opRsc, opMvn, opPassA})
    else $warning("operandStage: unlisted op %0h captured", reqData.op);

endmodule

`default_nettype wire

// ==== hdl/computeStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module computeStage
  import aluOpPkg::*, aluPipePkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       inValid,
  input  shiftedOp_t inData,
  output logic       hold,
  output logic       outValid,
  output computed_t  outData,
  input  logic       downHold
);

  logic                   invA;
  logic                   invB;
  logic                   useCarry;
  logic                   usesAdder;
  logic [dataWidth-1:0]   sum;
  logic                   carryOut;
  logic                   overflow;
  logic [2*dataWidth-1:0] product;
  logic                   ltSigned;
  logic                   ltUnsigned;
  logic [dataWidth-1:0]   value;
  computed_t              stageIn;

  // adder control per operation
  always_comb begin
    invA      = 1'b0;
    invB      = 1'b0;
    useCarry  = 1'b0;
    usesAdder = 1'b1;
    case (inData.op)
      opAdd: usesAdder = 1'b1;
      opSub, opSlt, opSltu: invB = 1'b1;
      opRsb: invA = 1'b1;
      opAdc: useCarry = 1'b1;
      opSbc: begin
        invB     = 1'b1;
        useCarry = 1'b1;
      end
      opRsc: begin
        invA     = 1'b1;
        useCarry = 1'b1;
      end
      default: usesAdder = 1'b0;
    endcase
  end

  addSub adder (
    .a        (inData.op1),
    .b        (inData.opB),
    .invA     (invA),
    .invB     (invB),
    .useCarry (useCarry),
    .carryIn  (inData.flagsIn[flagC]),
    .sum      (sum),
    .carryOut (carryOut),
    .overflow (overflow)
  );

  multiplier mul (
    .a       (inData.op1),
    .b       (inData.opB),
    .product (product)
  );

  assign ltSigned   = sum[dataWidth-1] ^ overflow;
  assign ltUnsigned = ~carryOut; // borrow out of op1 - opB

  always_comb begin
    case (inData.op)
      opAdd, opSub, opRsb, opAdc, opSbc, opRsc: value = sum;
      opAnd:   value = inData.op1 & inData.opB;
      opOr:    value = inData.op1 | inData.opB;
      opXor:   value = inData.op1 ^ inData.opB;
      opPassB: value = inData.opB;
      opMvn:   value = ~inData.opB;
      opPassA: value = inData.op1;
      opBic:   value = inData.op1 & ~inData.opB;
      opMulLo: value = product[dataWidth-1:0];
      opMulHi: value = product[2*dataWidth-1:dataWidth];
      opSll, opSrl, opSra: value = inData.shiftOut;
      opSlt:   value = {{(dataWidth-1){1'b0}}, ltSigned};
      opSltu:  value = {{(dataWidth-1){1'b0}}, ltUnsigned};
      default: value = '0; // unlisted code
    endcase
  end

  always_comb begin
    stageIn.value       = value;
    stageIn.addCarry    = carryOut;
    stageIn.addOverflow = overflow;
    stageIn.usesAdder   = usesAdder;
    stageIn.flagsIn     = inData.flagsIn;
  end

  stageReg #(.payload_t(computed_t)) stage3Reg (
    .clk      (clk),
    .reset    (reset),
    .inValid  (inValid),
    .inData   (stageIn),
    .hold     (hold),
    .outValid (outValid),
    .outData  (outData),
    .downHold (downHold)
  );

endmodule

`default_nettype wire

// ==== hdl/resultStage.sv ====
`timescale 1ns/10ps
`default_nettype none

module resultStage
  import aluOpPkg::*, aluPipePkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       inValid,
  input  computed_t  inData,
  output logic       hold,
  output logic       resReq,
  output aluResult_t resData,
  input  logic       resAck
);

  aluResult_t formed;
  logic       take;

  always_comb begin
    formed.value        = inData.value;
    formed.flags[flagN] = inData.value[dataWidth-1];
    formed.flags[flagZ] = (inData.value == '0);
    // c and v pass through unless the adder produced them
    formed.flags[flagC] = inData.usesAdder ? inData.addCarry : inData.flagsIn[flagC];
    formed.flags[flagV] = inData.usesAdder ? inData.addOverflow : inData.flagsIn[flagV];
  end

  // output cycle open until the consumer has dropped resAck again
  assign hold = resReq | resAck;
  assign take = inValid & ~hold;

  always_ff @(posedge clk) begin
    if (reset) begin
      resReq <= 1'b0;
    end else if (take) begin
      resReq <= 1'b1;
    end else if (resReq && resAck) begin
      resReq <= 1'b0; // consumer has it
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      resData <= formed;
    end
  end

  resStable: assert property (@(posedge clk) disable iff (reset)
    resReq |=> $stable(resData))
    else $error("resultStage: resData changed during an open request");

endmodule

`default_nettype wire

// ==== hdl/aluPipeTop.sv ====
`timescale 1ns/10ps
`default_nettype none

module aluPipeTop
  import aluOpPkg::*, aluPipePkg::*;
(
  input  logic       clk,
  input  logic       reset,
  input  logic       reqValid,
  input  aluReq_t    reqData,
  output logic       reqAck,
  output logic       resReq,
  output aluResult_t resData,
  input  logic       resAck
);

  logic       s2Valid;
  shiftedOp_t s2Data;
  logic       s2Hold; // compute stage full and stuck
  logic       s3Valid;
  computed_t  s3Data;
  logic       s3Hold; // output handshake open

  operandStage operand (
    .clk      (clk),
    .reset    (reset),
    .reqValid (reqValid),
    .reqData  (reqData),
    .reqAck   (reqAck),
    .outValid (s2Valid),
    .outData  (s2Data),
    .downHold (s2Hold)
  );

  computeStage compute (
    .clk      (clk),
    .reset    (reset),
    .inValid  (s2Valid),
    .inData   (s2Data),
    .hold     (s2Hold),
    .outValid (s3Valid),
    .outData  (s3Data),
    .downHold (s3Hold)
  );

  resultStage result (
    .clk     (clk),
    .reset   (reset),
    .inValid (s3Valid),
    .inData  (s3Data),
    .hold    (s3Hold),
    .resReq  (resReq),
    .resData (resData),
    .resAck  (resAck)
  );

endmodule

`default_nettype wire

// ==== sim/aluPipeTb.sv ====
`timescale 1ns/10ps
`default_nettype none

module aluPipeTb
  import aluOpPkg::*, aluPipePkg::*;
();

  localparam int waitLimit  = 100;
  localparam int drainLimit = (pipeDepth + 1) * 16; // few items in flight at drain time
  localparam int sigReqAck  = 0;
  localparam int sigResReq  = 1;

  logic       clk = 1'b0;
  logic       reset;
  logic       reqValid;
  aluReq_t    reqData;
  logic       reqAck;
  logic       resReq;
  aluResult_t resData;
  logic       resAck;

  aluResult_t  expQ [$];
  string       tagQ [$];
  logic [31:0] stimLfsr = 32'hde8e_0fde;
  logic [31:0] gapLfsr  = 32'hde8e_0fde; // own stream for the consumer
  logic        ackDelayOn;
  logic        consumerBusy;
  int          valueErrors;
  int          flagErrors;
  int          levelErrors;
  int          ackTimeouts;
  int          resTimeouts;

  aluOp_t listedOps [20] = '{opAdd, opSub, opAnd, opOr, opXor, opSlt, opPassB, opSltu,
                             opSll, opSrl, opSra, opMulLo, opMulHi, opBic, opAdc, opSbc,
                             opRsb, opRsc, opMvn, opPassA};
  logic [31:0] edgeVal [5] = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000,
                               32'h7fff_ffff, 32'h0000_0001};

  aluPipeTop dut (
    .clk      (clk),
    .reset    (reset),
    .reqValid (reqValid),
    .reqData  (reqData),
    .reqAck   (reqAck),
    .resReq   (resReq),
    .resData  (resData),
    .resAck   (resAck)
  );

  always #10 clk = ~clk;

  // taps 32 22 2 1
  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic takeBits(inout logic [31:0] state, input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      state = lfsrStep(state);
      bits  = {bits[30:0], state[0]};
    end
  endtask

  function automatic aluResult_t refModel(input aluReq_t r);
    logic [31:0] src;
    logic [31:0] shOut;
    logic [31:0] opB;
    logic [31:0] ea;
    logic [31:0] eb;
    logic [31:0] val;
    logic [63:0] dbl;
    logic [63:0] prod;
    logic [32:0] uSum;
    logic [32:0] sSum;
    logic [4:0]  amt;
    shiftKind_t  kind;
    logic        cin;
    logic        useAdd;
    aluResult_t  res;
    if (r.isArm) begin
      src  = r.op2;
      amt  = r.shiftImm ? r.shiftAmt : r.op1[4:0];
      kind = r.shiftKind;
    end else begin
      src  = r.op1;
      amt  = r.op2[4:0];
      kind = (r.op == opSrl) ? shLsr : (r.op == opSra) ? shAsr : shLsl;
    end
    case (kind)
      shLsl: shOut = src << amt;
      shLsr: shOut = src >> amt;
      shAsr: shOut = $signed(src) >>> amt;
      default: begin
        dbl   = {src, src} >> amt; // rotate through a doubled word
        shOut = dbl[31:0];
      end
    endcase
    opB    = r.isArm ? shOut : r.op2;
    ea     = r.op1;
    eb     = opB;
    cin    = 1'b0;
    useAdd = 1'b1;
    case (r.op)
      opAdd: cin = 1'b0;
      opSub, opSlt, opSltu: begin
        eb  = ~opB;
        cin = 1'b1;
      end
      opRsb: begin
        ea  = ~r.op1;
        cin = 1'b1;
      end
      opAdc: cin = r.flagsIn[1];
      opSbc: begin
        eb  = ~opB;
        cin = r.flagsIn[1];
      end
      opRsc: begin
        ea  = ~r.op1;
        cin = r.flagsIn[1];
      end
      default: useAdd = 1'b0;
    endcase
    uSum = {1'b0, ea} + {1'b0, eb} + {32'b0, cin};
    sSum = {ea[31], ea} + {eb[31], eb} + {32'b0, cin}; // signed sum one bit wider
    prod = {32'b0, r.op1} * {32'b0, opB};
    case (r.op)
      opAdd, opSub, opRsb, opAdc, opSbc, opRsc: val = uSum[31:0];
      opAnd:   val = r.op1 & opB;
      opOr:    val = r.op1 | opB;
      opXor:   val = r.op1 ^ opB;
      opPassB: val = opB;
      opMvn:   val = ~opB;
      opPassA: val = r.op1;
      opBic:   val = r.op1 & ~opB;
      opMulLo: val = prod[31:0];
      opMulHi: val = prod[63:32];
      opSll, opSrl, opSra: val = shOut;
      opSlt:   val = {31'b0, $signed(r.op1) < $signed(opB)};
      opSltu:  val = {31'b0, r.op1 < opB};
      default: val = '0;
    endcase
    res.value = val;
    res.flags = {val[31], val == 32'h0,
                 useAdd ? uSum[32] : r.flagsIn[1],
                 useAdd ? (sSum[32] != sSum[31]) : r.flagsIn[0]};
    return res;
  endfunction

  function automatic aluReq_t makeReq(input logic isArm, input aluOp_t op,
                                      input logic [31:0] op1, input logic [31:0] op2,
                                      input logic [3:0] flags);
    aluReq_t r;
    r.isArm     = isArm;
    r.op        = op;
    r.op1       = op1;
    r.op2       = op2;
    r.shiftKind = shLsl; // lsl by 0 leaves op2 alone
    r.shiftImm  = 1'b1;
    r.shiftAmt  = '0;
    r.flagsIn   = flags;
    return r;
  endfunction

  function automatic logic probe(input int which);
    return (which == sigReqAck) ? reqAck : resReq;
  endfunction

  task automatic nextCycle();
    @(posedge clk);
    #2;
  endtask

  task automatic waitFor(input int which, input logic level, input string what,
                         output logic ok);
    int cycles;
    cycles = 0;
    while (probe(which) !== level && cycles < waitLimit) begin
      nextCycle();
      cycles++;
    end
    ok = (probe(which) === level);
    if (!ok) begin
      $display("Timed out after %0d cycles waiting for %s", waitLimit, what);
    end
  endtask

  task automatic checkResult(input aluResult_t got, input aluResult_t exp, input string tag);
    if (got.value !== exp.value) begin
      valueErrors++;
      $display("** Error: resData.value (%s) got %h expected %h", tag, got.value, exp.value);
    end
    if (got.flags !== exp.flags) begin
      flagErrors++;
      $display("** Error: resData.flags (%s) got %h expected %h", tag, got.flags, exp.flags);
    end
  endtask

  task automatic checkLevel(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      levelErrors++;
      $display("** Error: %s got %h expected %h", name, got, exp);
    end
  endtask

  // four-phase request, expected result queued once captured
  task automatic sendReq(input aluReq_t r, input string tag);
    logic ok;
    reqData  = r;
    reqValid = 1'b1;
    waitFor(sigReqAck, 1'b1, "reqAck to rise", ok);
    if (ok) begin
      expQ.push_back(refModel(r));
      tagQ.push_back(tag);
    end else begin
      ackTimeouts++;
    end
    reqValid = 1'b0;
    waitFor(sigReqAck, 1'b0, "reqAck to fall", ok);
    if (!ok) begin
      ackTimeouts++;
    end
  endtask

  task automatic randomReq(output aluReq_t r);
    logic [31:0] bits;
    takeBits(stimLfsr, 5, bits);
    r.op = listedOps[bits % 20];
    takeBits(stimLfsr, 32, bits);
    r.op1 = bits;
    takeBits(stimLfsr, 32, bits);
    r.op2 = bits;
    takeBits(stimLfsr, 13, bits);
    r.isArm     = bits[12];
    r.shiftKind = shiftKind_t'(bits[11:10]);
    r.shiftImm  = bits[9];
    r.shiftAmt  = bits[8:4];
    r.flagsIn   = bits[3:0];
  endtask

  task automatic drain(input string what);
    int cycles;
    cycles = 0;
    while ((expQ.size() != 0 || consumerBusy) && cycles < drainLimit) begin
      nextCycle();
      cycles++;
    end
    if (expQ.size() != 0 || consumerBusy) begin
      resTimeouts++;
      $display("Results of %s still missing after %0d cycles", what, drainLimit);
    end
    repeat (pipeDepth + 2) begin
      nextCycle();
      checkLevel("resReq", resReq, 1'b0); // nothing extra comes out
    end
  endtask

  task automatic testArith();
    aluOp_t ops [6];
    ops = '{opAdd, opSub, opRsb, opAdc, opSbc, opRsc};
    foreach (ops[k]) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          sendReq(makeReq(1'b1, ops[k], edgeVal[i], edgeVal[j], 4'b0010), "arith c1");
          sendReq(makeReq(1'b1, ops[k], edgeVal[i], edgeVal[j], 4'b1101), "arith c0");
        end
      end
    end
    drain("testArith");
  endtask

  task automatic testLogicPass();
    aluOp_t      ops [7];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] f;
    ops = '{opAnd, opOr, opXor, opBic, opMvn, opPassA, opPassB};
    foreach (ops[k]) begin
      for (int n = 0; n < 8; n++) begin
        takeBits(stimLfsr, 32, a);
        takeBits(stimLfsr, 32, b);
        takeBits(stimLfsr, 5, f);
        // bic, mvn and passA exist only on arm
        sendReq(makeReq((k >= 3 && k <= 5) ? 1'b1 : f[4], ops[k], a, b, f[3:0]), "logic");
      end
    end
    drain("testLogicPass");
  endtask

  task automatic testShift();
    aluOp_t      rvOps [3];
    aluOp_t      armOps [2];
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] f;
    aluReq_t     r;
    rvOps  = '{opSll, opSrl, opSra};
    armOps = '{opAdd, opPassB};
    for (int s = 0; s < 32; s++) begin
      foreach (rvOps[k]) begin
        takeBits(stimLfsr, 32, a);
        takeBits(stimLfsr, 32, b);
        sendReq(makeReq(1'b0, rvOps[k], a, {b[31:5], 5'(s)}, b[3:0]), "rv shift");
      end
    end
    foreach (armOps[k]) begin
      for (int kind = 0; kind < 4; kind++) begin
        for (int imm = 0; imm < 2; imm++) begin
          for (int s = 0; s < 32; s++) begin
            takeBits(stimLfsr, 32, a);
            takeBits(stimLfsr, 32, b);
            takeBits(stimLfsr, 4, f);
            // unused amount source holds the inverse, so a wrong pick shows
            r = makeReq(1'b1, armOps[k], {a[31:5], imm[0] ? ~5'(s) : 5'(s)}, b, f[3:0]);
            r.shiftKind = shiftKind_t'(kind[1:0]);
            r.shiftImm  = imm[0];
            r.shiftAmt  = imm[0] ? 5'(s) : ~5'(s);
            sendReq(r, "arm shift");
          end
        end
      end
    end
    drain("testShift");
  endtask

  task automatic testCompareMul();
    logic [31:0] a;
    logic [31:0] b;
    for (int i = 0; i < 5; i++) begin
      for (int j = 0; j < 5; j++) begin
        sendReq(makeReq(1'b0, opSlt, edgeVal[i], edgeVal[j], 4'b0000), "slt");
        sendReq(makeReq(1'b0, opSltu, edgeVal[i], edgeVal[j], 4'b1111), "sltu");
      end
    end
    for (int n = 0; n < 200; n++) begin
      takeBits(stimLfsr, 32, a);
      takeBits(stimLfsr, 32, b);
      sendReq(makeReq(1'b0, opMulLo, a, b, a[3:0]), "mul lo");
      sendReq(makeReq(1'b0, opMulHi, a, b, b[3:0]), "mul hi");
    end
    drain("testCompareMul");
  endtask

  task automatic testBackPressure();
    aluReq_t r;
    ackDelayOn = 1'b1;
    repeat (50) begin
      randomReq(r);
      sendReq(r, "stream");
    end
    drain("testBackPressure");
    ackDelayOn = 1'b0;
  endtask

  task automatic testReset();
    logic ok;
    // park one item at the output with no consumer, reqAck still up
    reqData  = makeReq(1'b1, opAdd, 32'h0000_0005, 32'h0000_0007, 4'b0000);
    reqValid = 1'b1; // kept high through reset
    waitFor(sigReqAck, 1'b1, "reqAck to rise", ok);
    if (!ok) begin
      ackTimeouts++;
    end
    waitFor(sigResReq, 1'b1, "resReq to rise", ok);
    if (!ok) begin
      resTimeouts++;
    end
    reset = 1'b1;
    repeat (4) begin
      nextCycle();
      checkLevel("reqAck", reqAck, 1'b0);
      checkLevel("resReq", resReq, 1'b0);
    end
    reqValid = 1'b0;
    nextCycle();
    reset = 1'b0;
    sendReq(makeReq(1'b1, aluOp_t'(5'h18), 32'h1234_5678, 32'hffff_0000, 4'b1111),
            "unlisted");
    sendReq(makeReq(1'b0, aluOp_t'(5'h0b), 32'h8000_0000, 32'h0000_0003, 4'b0000),
            "unlisted");
    drain("testReset");
  endtask

  // pops one expected result per output handshake
  initial begin : consumer
    aluResult_t  exp;
    string       tag;
    logic [31:0] gapBits;
    logic        ok;
    resAck       = 1'b0;
    consumerBusy = 1'b0;
    forever begin
      nextCycle();
      if (expQ.size() > 0) begin
        consumerBusy = 1'b1;
        waitFor(sigResReq, 1'b1, "resReq to rise", ok);
        exp = expQ.pop_front();
        tag = tagQ.pop_front();
        if (ok) begin
          checkResult(resData, exp, tag);
        end else begin
          resTimeouts++;
        end
        takeBits(gapLfsr, 3, gapBits);
        if (!ackDelayOn) begin
          gapBits = '0;
        end
        repeat (gapBits[2:0]) begin
          nextCycle();
        end
        resAck = 1'b1;
        waitFor(sigResReq, 1'b0, "resReq to fall", ok);
        if (!ok) begin
          resTimeouts++;
        end
        resAck       = 1'b0;
        consumerBusy = 1'b0;
      end
    end
  end

  initial begin
    reset       = 1'b1;
    reqValid    = 1'b0;
    reqData     = '0;
    ackDelayOn  = 1'b0;
    valueErrors = 0;
    flagErrors  = 0;
    levelErrors = 0;
    ackTimeouts = 0;
    resTimeouts = 0;
    repeat (10) begin
      nextCycle();
    end
    reset = 1'b0;
    testArith();
    testLogicPass();
    testShift();
    testCompareMul();
    testBackPressure();
    testReset();
    $display("errors: value %0d, flags %0d, level %0d, timeouts %0d", valueErrors,
             flagErrors, levelErrors, ackTimeouts + resTimeouts);
    if (valueErrors + flagErrors + levelErrors + ackTimeouts + resTimeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim.f ====
hdl/aluOpPkg.sv
hdl/aluPipePkg.sv
hdl/stageReg.sv
hdl/barrelShifter.sv
hdl/addSub.sv
hdl/multiplier.sv
hdl/operandStage.sv
hdl/computeStage.sv
hdl/resultStage.sv
hdl/aluPipeTop.sv
sim/aluPipeTb.sv

// ==== Makefile ====
# Verilator build and run of the ALU pipeline testbench

VERILATOR ?= verilator
TOP       ?= aluPipeTb
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and check the log for the pass message"
	@echo "  clean  remove the build directory and the log"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
